// File: Bender.yml
package:
  name: alu_core

dependencies: {}

sources:
  - files:
      - rtl/corePkg.sv
      - rtl/regFile.sv
      - rtl/decodeStage.sv
      - rtl/executeStage.sv
      - rtl/aluCore.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/tbAluCore.sv

// File: filelist.f
+incdir+tests
rtl/corePkg.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/aluCore.sv
tests/tbAluCore.sv

// File: rtl/aluCore.sv
`timescale 1ns/1ps

module aluCore (
   input  logic             clk,
   input  logic             arstN,
   input  logic             instrValid,
   output logic             instrReady,
   input  corePkg::instr_t  instr,
   output logic             resultValid,
   input  logic             resultReady,
   output corePkg::result_t result,
   output logic             err
);

   corePkg::regIdx_t   readSel1;
   corePkg::regIdx_t   readSel2;
   corePkg::word_t     readData1;
   corePkg::word_t     readData2;
   logic               exFwdValid;
   corePkg::result_t   exFwd;
   logic               opValid;
   logic               opReady;
   corePkg::operands_t ops;

   //////////////////////////////////////////////////
   // Pipeline
   //////////////////////////////////////////////////

   decodeStage i_decodeStage (
      .clk        (clk),
      .arstN      (arstN),
      .instrValid (instrValid),
      .instrReady (instrReady),
      .instr      (instr),
      .readSel1   (readSel1),
      .readSel2   (readSel2),
      .readData1  (readData1),
      .readData2  (readData2),
      .exFwdValid (exFwdValid),
      .exFwd      (exFwd),
      .wbFwdValid (resultValid),   // Result register is the older bypass
      .wbFwd      (result),
      .opValid    (opValid),
      .opReady    (opReady),
      .ops        (ops),
      .err        (err)
   );

   executeStage i_executeStage (
      .clk         (clk),
      .arstN       (arstN),
      .opValid     (opValid),
      .opReady     (opReady),
      .ops         (ops),
      .exFwdValid  (exFwdValid),
      .exFwd       (exFwd),
      .resultValid (resultValid),
      .resultReady (resultReady),
      .result      (result)
   );

   // Written when the result record leaves
   regFile i_regFile (
      .clk       (clk),
      .arstN     (arstN),
      .readSel1  (readSel1),
      .readSel2  (readSel2),
      .readData1 (readData1),
      .readData2 (readData2),
      .writeEn   (resultValid && resultReady),
      .writeSel  (result.rd),
      .writeData (result.value)
   );

endmodule

// File: rtl/corePkg.sv
package corePkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIdx_t;
   typedef logic [15:0] instr_t;

   //////////////////////////////////////////////////
   // Instruction layout
   //////////////////////////////////////////////////

   localparam int OpcodeHi = 15;
   localparam int OpcodeLo = 12;
   localparam int RdHi     = 11;
   localparam int RdLo     = 9;
   localparam int RsHi     = 8;
   localparam int RsLo     = 6;
   localparam int RtHi     = 5;
   localparam int RtLo     = 3;
   localparam int Imm6Hi   = 5;   // Signed, bits 5..0
   localparam int Imm9Hi   = 8;   // Signed, bits 8..0, LI only

   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_OR   = 4'd4,
      OP_XOR  = 4'd5,
      OP_SHL  = 4'd6,
      OP_SHR  = 4'd7,
      OP_ADDI = 4'd8,
      OP_LI   = 4'd9
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SHL,
      ALU_SHR,
      ALU_PASSB
   } aluOp_e;

   //////////////////////////////////////////////////
   // Stage records
   //////////////////////////////////////////////////

   typedef struct packed {
      aluOp_e  aluOp;
      regIdx_t rd;
      word_t   a;
      word_t   b;      // Already the immediate for ADDI and LI
   } operands_t;

   typedef struct packed {
      regIdx_t rd;
      word_t   value;
   } result_t;

endpackage

// File: rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
   input  logic               clk,
   input  logic               arstN,
   input  logic               instrValid,
   output logic               instrReady,
   input  corePkg::instr_t    instr,
   output corePkg::regIdx_t   readSel1,
   output corePkg::regIdx_t   readSel2,
   input  corePkg::word_t     readData1,
   input  corePkg::word_t     readData2,
   input  logic               exFwdValid,
   input  corePkg::result_t   exFwd,
   input  logic               wbFwdValid,
   input  corePkg::result_t   wbFwd,
   output logic               opValid,
   input  logic               opReady,
   output corePkg::operands_t ops,
   output logic               err
);

   corePkg::opcode_e   opcode;
   corePkg::regIdx_t   rd;
   corePkg::regIdx_t   rs;
   corePkg::regIdx_t   rt;
   corePkg::word_t     imm6;
   corePkg::word_t     imm9;
   corePkg::word_t     rsVal;
   corePkg::word_t     rtVal;
   corePkg::operands_t opsNext;
   logic               legal;
   logic               writesReg;
   logic               accept;

   function automatic corePkg::word_t pickOperand(
      input corePkg::regIdx_t idx,
      input corePkg::word_t   rfData,
      input logic             exValid,
      input corePkg::result_t ex,
      input logic             wbValid,
      input corePkg::result_t wb
   );
      if (exValid && ex.rd == idx) begin
         return ex.value;   // Youngest result wins
      end
      if (wbValid && wb.rd == idx) begin
         return wb.value;
      end
      return rfData;
   endfunction

   //////////////////////////////////////////////////
   // Field split and operand read
   //////////////////////////////////////////////////

   assign opcode = corePkg::opcode_e'(instr[corePkg::OpcodeHi:corePkg::OpcodeLo]);
   assign rd     = instr[corePkg::RdHi:corePkg::RdLo];
   assign rs     = instr[corePkg::RsHi:corePkg::RsLo];
   assign rt     = instr[corePkg::RtHi:corePkg::RtLo];
   assign imm6   = {{10{instr[corePkg::Imm6Hi]}}, instr[corePkg::Imm6Hi:0]};
   assign imm9   = {{7{instr[corePkg::Imm9Hi]}}, instr[corePkg::Imm9Hi:0]};

   assign readSel1 = rs;
   assign readSel2 = rt;
   assign rsVal    = pickOperand(rs, readData1, exFwdValid, exFwd, wbFwdValid, wbFwd);
   assign rtVal    = pickOperand(rt, readData2, exFwdValid, exFwd, wbFwdValid, wbFwd);

   always_comb begin
      legal         = 1'b1;
      writesReg     = 1'b1;
      opsNext.aluOp = corePkg::ALU_ADD;
      opsNext.rd    = rd;
      opsNext.a     = rsVal;
      opsNext.b     = rtVal;
      case (opcode)
         corePkg::OP_NOP:  writesReg = 1'b0;
         corePkg::OP_ADD:  opsNext.aluOp = corePkg::ALU_ADD;
         corePkg::OP_SUB:  opsNext.aluOp = corePkg::ALU_SUB;
         corePkg::OP_AND:  opsNext.aluOp = corePkg::ALU_AND;
         corePkg::OP_OR:   opsNext.aluOp = corePkg::ALU_OR;
         corePkg::OP_XOR:  opsNext.aluOp = corePkg::ALU_XOR;
         corePkg::OP_SHL:  opsNext.aluOp = corePkg::ALU_SHL;
         corePkg::OP_SHR:  opsNext.aluOp = corePkg::ALU_SHR;
         corePkg::OP_ADDI: begin
            opsNext.aluOp = corePkg::ALU_ADD;
            opsNext.b     = imm6;
         end
         corePkg::OP_LI: begin
            opsNext.aluOp = corePkg::ALU_PASSB;
            opsNext.a     = '0;
            opsNext.b     = imm9;
         end
         default: begin   // Accepted and dropped
            legal     = 1'b0;
            writesReg = 1'b0;
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Operand register
   //////////////////////////////////////////////////

   assign instrReady = !opValid || opReady;
   assign accept     = instrValid && instrReady;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         opValid <= 1'b0;
         err     <= 1'b0;
      end else begin
         if (accept && writesReg) begin
            opValid <= 1'b1;
         end else if (opReady) begin
            opValid <= 1'b0;
         end
         if (accept && !legal) begin
            err <= 1'b1;   // Sticky until reset
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && writesReg) begin
         ops <= opsNext;
      end
   end

   property pOpsHeld;
      @(posedge clk) disable iff (!arstN)
         opValid && !opReady |=> opValid && $stable(ops);
   endproperty

   aOpsHeld : assert property (pOpsHeld)
      else $error("operand record changed under back-pressure");

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage (
   input  logic               clk,
   input  logic               arstN,
   input  logic               opValid,
   output logic               opReady,
   input  corePkg::operands_t ops,
   output logic               exFwdValid,
   output corePkg::result_t   exFwd,
   output logic               resultValid,
   input  logic               resultReady,
   output corePkg::result_t   result
);

   corePkg::word_t aluValue;
   logic           transfer;

   //////////////////////////////////////////////////
   // ALU
   //////////////////////////////////////////////////

   always_comb begin
      case (ops.aluOp)
         corePkg::ALU_ADD: aluValue = ops.a + ops.b;   // Wraps at 16 bits
         corePkg::ALU_SUB: aluValue = ops.a - ops.b;
         corePkg::ALU_AND: aluValue = ops.a & ops.b;
         corePkg::ALU_OR:  aluValue = ops.a | ops.b;
         corePkg::ALU_XOR: aluValue = ops.a ^ ops.b;
         corePkg::ALU_SHL: aluValue = ops.a << ops.b[3:0];
         corePkg::ALU_SHR: aluValue = ops.a >> ops.b[3:0];
         default:          aluValue = ops.b;   // PASSB
      endcase
   end

   // Youngest bypass source
   assign exFwdValid  = opValid;
   assign exFwd.rd    = ops.rd;
   assign exFwd.value = aluValue;

   //////////////////////////////////////////////////
   // Result register
   //////////////////////////////////////////////////

   assign opReady  = !resultValid || resultReady;
   assign transfer = opValid && opReady;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         resultValid <= 1'b0;
      end else if (transfer) begin
         resultValid <= 1'b1;
      end else if (resultReady) begin
         resultValid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (transfer) begin
         result.rd    <= ops.rd;
         result.value <= aluValue;
      end
   end

   // Stream rule seen at the core boundary
   property pResultHeld;
      @(posedge clk) disable iff (!arstN)
         resultValid && !resultReady |=> resultValid && $stable(result);
   endproperty

   aResultHeld : assert property (pResultHeld)
      else $error("result dropped or changed before transfer");

endmodule

// File: rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
   input  logic             clk,
   input  logic             arstN,
   input  corePkg::regIdx_t readSel1,
   input  corePkg::regIdx_t readSel2,
   output corePkg::word_t   readData1,
   output corePkg::word_t   readData2,
   input  logic             writeEn,
   input  corePkg::regIdx_t writeSel,
   input  corePkg::word_t   writeData
);

   corePkg::word_t regs [8];

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeSel] <= writeData;
      end
   end

   // Old value during a same-cycle write
   assign readData1 = regs[readSel1];
   assign readData2 = regs[readSel2];

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   property pWriteSelKnown;
      @(posedge clk) disable iff (!arstN)
         writeEn |-> !$isunknown(writeSel);
   endproperty

   aWriteSelKnown : assert property (pWriteSelKnown)
      else $error("regFile write with unknown select");

endmodule

// File: tests/tbTasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

//////////////////////////////////////////////////
// Instruction builders
//////////////////////////////////////////////////

function automatic corePkg::instr_t rType(input logic [3:0] op, input int rd, input int rs,
                                          input int rt);
   return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
endfunction

function automatic corePkg::instr_t addImm(input int rd, input int rs, input int imm);
   return {corePkg::OP_ADDI, 3'(rd), 3'(rs), 6'(imm)};
endfunction

function automatic corePkg::instr_t loadImm(input int rd, input int imm);
   return {corePkg::OP_LI, 3'(rd), 9'(imm)};
endfunction

function automatic corePkg::instr_t randomInstr();
   logic [3:0] op;
   op = 4'($urandom_range(0, 9));   // Legal opcodes only, NOP included
   return {op, 12'($urandom)};
endfunction

//////////////////////////////////////////////////
// Reference model and checks
//////////////////////////////////////////////////

task automatic modelExpect(input corePkg::instr_t ins);
   logic [15:0]      a;
   logic [15:0]      b;
   logic [15:0]      v;
   logic             hasResult;
   corePkg::result_t rec;
   a         = modelRegs[ins[8:6]];
   b         = modelRegs[ins[5:3]];
   v         = '0;
   hasResult = 1'b1;
   case (ins[15:12])
      4'd1:    v = a + b;
      4'd2:    v = a - b;
      4'd3:    v = a & b;
      4'd4:    v = a | b;
      4'd5:    v = a ^ b;
      4'd6:    v = a << b[3:0];
      4'd7:    v = a >> b[3:0];
      4'd8:    v = a + {{10{ins[5]}}, ins[5:0]};
      4'd9:    v = {{7{ins[8]}}, ins[8:0]};
      default: hasResult = 1'b0;   // NOP and illegal codes
   endcase
   if (hasResult) begin
      rec.rd    = ins[11:9];
      rec.value = v;
      expQ.push_back(rec);
      modelRegs[ins[11:9]] = v;
   end
endtask

task automatic checkEqual(input string what, input logic [31:0] got, input logic [31:0] exp);
   if (got !== exp) begin
      errorCount++;
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
   end
endtask

task automatic reportTimeout(input string what);
   errorCount++;
   $display("Timed out %s at %0t", what, $time);
   finishRun();
endtask

// Called at the falling edge, a handshake seen here completes on the next rising edge
task automatic collectResult();
   corePkg::result_t expRec;
   if (resultValid && resultReady) begin
      if (expQ.size() == 0) begin
         errorCount++;
         $display("Unexpected result r%0d = %h at %0t", result.rd, result.value, $time);
      end else begin
         expRec = expQ.pop_front();
         checkEqual("result rd", result.rd, expRec.rd);
         checkEqual("result value", result.value, expRec.value);
         resultCount++;
      end
   end
endtask

//////////////////////////////////////////////////
// Stream driver
//////////////////////////////////////////////////

task automatic sendInstr(input corePkg::instr_t ins);
   int cycles;
   cycles     = 0;
   instrValid = 1'b1;
   instr      = ins;
   @(negedge clk);
   while (!instrReady) begin
      cycles++;
      if (cycles > TimeoutCycles) begin
         reportTimeout("waiting for instrReady");
      end
      @(negedge clk);
   end
   @(posedge clk);
   #2;
   instrValid = 1'b0;
   modelExpect(ins);
endtask

task automatic waitDrained(input string where);
   int cycles;
   cycles = 0;
   while (expQ.size() != 0) begin
      if (cycles > TimeoutCycles) begin
         reportTimeout({"draining results in ", where});
      end
      @(posedge clk);
      #2;
      cycles++;
   end
   repeat (4) begin
      @(posedge clk);
      #2;
   end
   checkEqual({where, " resultValid after drain"}, resultValid, 0);
endtask

`endif

// File: tests/tbAluCore.sv
`timescale 1ns/1ps

module tbAluCore;

   localparam int TimeoutCycles = 2000;
   localparam int ReadyHigh     = 0;
   localparam int ReadyLow      = 1;
   localparam int ReadyRandom   = 2;

   logic             clk;
   logic             arstN;
   logic             instrValid;
   logic             instrReady;
   corePkg::instr_t  instr;
   logic             resultValid;
   logic             resultReady;
   corePkg::result_t result;
   logic             err;

   int               errorCount;
   int               resultCount;
   int               readyMode;
   int               seedValue;
   corePkg::word_t   modelRegs [8];
   corePkg::result_t expQ [$];

   aluCore i_aluCore (
      .clk         (clk),
      .arstN       (arstN),
      .instrValid  (instrValid),
      .instrReady  (instrReady),
      .instr       (instr),
      .resultValid (resultValid),
      .resultReady (resultReady),
      .result      (result),
      .err         (err)
   );

   task automatic finishRun();
      $display("Run ended with %0d errors, %0d results checked", errorCount, resultCount);
      if (errorCount == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   endtask

   `include "tbTasks.svh"

   //////////////////////////////////////////////////
   // Clock, reset and result sink
   //////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Mode sampled on the edge and applied 2 ns later
   always @(posedge clk) begin
      int mode;
      mode = readyMode;
      #2;
      case (mode)
         ReadyLow:    resultReady = 1'b0;
         ReadyRandom: resultReady = 1'($urandom_range(0, 1));
         default:     resultReady = 1'b1;
      endcase
   end

   always @(negedge clk) begin
      if (arstN) begin
         collectResult();
      end
   end

   task automatic applyReset();
      arstN      = 1'b0;
      instrValid = 1'b0;
      for (int i = 0; i < 8; i++) begin
         modelRegs[i] = '0;
      end
      expQ.delete();
      repeat (16) @(posedge clk);
      #2;
      arstN = 1'b1;
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic testReset();
      checkEqual("resultValid after reset", resultValid, 0);
      checkEqual("err after reset", err, 0);
      checkEqual("instrReady after reset", instrReady, 1);
      for (int i = 0; i < 8; i++) begin
         sendInstr(rType(corePkg::OP_ADD, i, i, 0));   // Every register reads zero
      end
      sendInstr(rType(corePkg::OP_ADD, 1, 0, 0));
      waitDrained("reset test");
   endtask

   task automatic testOpcodes();
      sendInstr(loadImm(1, 9'h0a5));
      sendInstr(loadImm(2, -3));
      sendInstr(loadImm(3, 15));
      sendInstr(loadImm(4, 0));
      sendInstr(loadImm(5, -256));
      sendInstr(rType(corePkg::OP_ADD, 6, 1, 2));
      sendInstr(rType(corePkg::OP_ADD, 6, 5, 5));
      sendInstr(rType(corePkg::OP_SUB, 6, 4, 1));   // Wraps below zero
      sendInstr(rType(corePkg::OP_SUB, 6, 5, 2));
      sendInstr(rType(corePkg::OP_AND, 6, 1, 2));
      sendInstr(rType(corePkg::OP_OR, 6, 1, 5));
      sendInstr(rType(corePkg::OP_XOR, 6, 2, 5));
      sendInstr(rType(corePkg::OP_SHL, 6, 1, 3));
      sendInstr(rType(corePkg::OP_SHL, 6, 1, 4));
      sendInstr(rType(corePkg::OP_SHR, 6, 5, 3));
      sendInstr(rType(corePkg::OP_SHR, 6, 2, 4));
      sendInstr(addImm(6, 1, -32));
      sendInstr(addImm(7, 4, -1));
      sendInstr(addImm(7, 7, 1));                   // 0xffff + 1 wraps to zero
      sendInstr(addImm(7, 2, 31));
      waitDrained("opcode test");
   endtask

   task automatic testBypass();
      sendInstr(loadImm(2, 7));
      sendInstr(rType(corePkg::OP_ADD, 3, 2, 2));
      sendInstr(rType(corePkg::OP_SUB, 4, 3, 2));
      sendInstr(rType(corePkg::OP_XOR, 5, 4, 3));
      sendInstr(rType(corePkg::OP_ADD, 5, 5, 5));
      sendInstr(addImm(2, 2, 1));
      sendInstr(rType(corePkg::OP_ADD, 6, 2, 4));   // r4 comes from the register file
      sendInstr(rType(corePkg::OP_SHL, 7, 6, 2));
      waitDrained("bypass test");
   endtask

   task automatic testBackPressure();
      readyMode = ReadyLow;
      @(posedge clk);
      #2;
      sendInstr(loadImm(1, 11));
      sendInstr(addImm(2, 1, 5));
      instrValid = 1'b1;
      instr      = rType(corePkg::OP_ADD, 3, 1, 2);
      repeat (24) begin
         @(negedge clk);
         checkEqual("instrReady during stall", instrReady, 0);
      end
      checkEqual("resultValid during stall", resultValid, 1);
      @(posedge clk);
      #2;
      instrValid = 1'b0;
      readyMode  = ReadyRandom;
      sendInstr(rType(corePkg::OP_ADD, 3, 1, 2));
      for (int i = 0; i < 16; i++) begin
         sendInstr(randomInstr());
      end
      waitDrained("back-pressure test");
      readyMode = ReadyHigh;
   endtask

   task automatic testNopIllegal();
      sendInstr(loadImm(1, 5));
      sendInstr(rType(corePkg::OP_NOP, 1, 1, 1));
      sendInstr(rType(corePkg::OP_ADD, 2, 1, 1));
      checkEqual("err before illegal opcode", err, 0);
      sendInstr(rType(4'hc, 1, 2, 2));   // Must leave r1 alone
      checkEqual("err after illegal opcode", err, 1);
      sendInstr(rType(corePkg::OP_ADD, 3, 1, 0));
      sendInstr(rType(4'hf, 3, 3, 3));
      sendInstr(rType(corePkg::OP_SUB, 4, 3, 2));
      waitDrained("NOP and illegal test");
      checkEqual("err held high", err, 1);
      applyReset();
      checkEqual("err after second reset", err, 0);
   endtask

   task automatic testRandomStream();
      int gap;
      readyMode = ReadyRandom;
      for (int i = 0; i < 300; i++) begin
         gap = $urandom_range(0, 3);
         repeat (gap) begin
            @(posedge clk);
            #2;
         end
         sendInstr(randomInstr());
      end
      waitDrained("random stream");
      readyMode = ReadyHigh;
   endtask

   //////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////

   initial begin
      seedValue   = $urandom(80);
      errorCount  = 0;
      resultCount = 0;
      readyMode   = ReadyHigh;
      arstN       = 1'b0;
      instrValid  = 1'b0;
      instr       = '0;
      resultReady = 1'b0;
      applyReset();
      testReset();
      testOpcodes();
      testBypass();
      testBackPressure();
      testNopIllegal();
      testRandomStream();
      finishRun();
   end

endmodule
